//--- bench/muldiv_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit_tb;

    localparam int max_vectors = 64;
    localparam int mul_latency = 35;  // Request register, 33 engine cycles, result register
    localparam int div_latency = 36;

    logic                        clk;
    logic                        reset;
    logic                        req;
    muldiv_pkg::muldiv_req_t     req_data;
    logic                        busy;
    logic                        result_valid;
    logic [rv_m_pkg::xlen-1:0]   result;

    logic [31:0] vec_mem [0:4*max_vectors];
    int          gap [0:max_vectors-1];
    int          num_vectors;
    int          timeout_limit;
    int          cycle_count = 0;
    int          valid_count = 0;
    int          pass_count;
    int          fail_count;
    int          held_count;
    bit          test_ok;

    muldiv_unit u_muldiv_unit (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .req_data     (req_data),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin
        if (result_valid === 1'b1)
            valid_count <= valid_count + 1;  // Every pulse, so a duplicate shows in the total
    end

    initial begin : watchdog
        @(posedge clk);
        while (cycle_count < timeout_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", timeout_limit);
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic muldiv_pkg::muldiv_req_t vector_request(input int idx);
        muldiv_pkg::muldiv_req_t r;
        r.op = rv_m_pkg::muldiv_op_e'(vec_mem[1+4*idx][2:0]);
        r.a  = vec_mem[2+4*idx];
        r.b  = vec_mem[3+4*idx];
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            test_ok = 1'b0;
        end
    endtask

    task automatic run_vector(input int idx);
        muldiv_pkg::muldiv_req_t r;
        logic [31:0]             expected;
        int                      expected_latency;
        int                      latency;
        r                = vector_request(idx);
        expected         = vec_mem[4+4*idx];
        expected_latency = (r.op >= rv_m_pkg::op_div) ? div_latency : mul_latency;
        latency          = 0;
        test_ok          = 1'b1;
        if (idx == 0 || gap[idx] != 0) begin
            repeat ((gap[idx] > 0) ? gap[idx] : 1) @(posedge clk);
            req      <= 1'b1;
            req_data <= r;
            @(negedge clk);
        end else begin
            held_count++;  // Already on req since the previous acceptance
        end
        while (busy) @(negedge clk);
        @(posedge clk);  // Accepting edge
        if (idx + 1 < num_vectors && gap[idx+1] == 0)
            req_data <= vector_request(idx + 1);  // Kept on req while busy, must be ignored
        else
            req <= 1'b0;
        do begin
            @(posedge clk);
            latency++;
            @(negedge clk);
            if (result_valid !== 1'b1)
                check_value("busy", 32'd1, 32'(busy));
        end while (result_valid !== 1'b1);
        check_value("result", expected, result);
        check_count("result_valid latency", expected_latency, latency);
        check_value("busy", 32'd0, 32'(busy));
        if (test_ok)
            pass_count++;
        else
            fail_count++;
        $display("Test %0d %s a=%h b=%h result=%h gap=%0d %s", idx, r.op.name(), r.a, r.b,
                 result, gap[idx], test_ok ? "ok" : "FAILED");
    endtask

    initial begin
        void'($urandom(90));
        reset      = 1'b1;
        req        = 1'b0;
        req_data   = '0;
        pass_count = 0;
        fail_count = 0;
        held_count = 0;
        $readmemh("bench/muldiv_vectors.txt", vec_mem);
        num_vectors   = int'(vec_mem[0]);
        timeout_limit = num_vectors * 40 + 100;
        for (int i = 0; i < num_vectors; i++)
            gap[i] = int'($urandom % 4);

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        test_ok = 1'b1;
        check_value("busy", 32'd0, 32'(busy));
        check_value("result_valid", 32'd0, 32'(result_valid));
        check_value("result", 32'd0, result);
        if (test_ok)
            pass_count++;
        else
            fail_count++;
        $display("Test reset busy=%b result_valid=%b result=%h %s", busy, result_valid,
                 result, test_ok ? "ok" : "FAILED");

        for (int i = 0; i < num_vectors; i++)
            run_vector(i);

        repeat (2) @(posedge clk);
        @(negedge clk);
        assert (valid_count == num_vectors) else begin
            $display("Error at %0t: result_valid pulses expected %0d, got %0d", $time,
                     num_vectors, valid_count);
            fail_count++;
        end
        assert (held_count > 0) else begin
            $display("No request was held on req across a busy period");
            fail_count++;
        end

        $display("Passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/muldiv_vectors.txt
// Columns: op, operand a, operand b, expected result, all hex; op is funct3 (0 mul .. 7 remu)
// The first word is the number of vectors that follow
00000026
0 00000007 00000006 0000002A
0 FFFFFFFF 00000005 FFFFFFFB
0 FFFFFFFD FFFFFFF9 00000015
0 12345678 00000010 23456780
0 80000000 00000002 00000000
1 00000007 00000006 00000000
1 FFFFFFFF 00000005 FFFFFFFF
1 80000000 80000000 40000000
1 7FFFFFFF 7FFFFFFF 3FFFFFFF
1 80000000 00000002 FFFFFFFF
1 FFFFFFFE 00010000 FFFFFFFF
2 FFFFFFFF FFFFFFFF FFFFFFFF
2 80000000 80000000 C0000000
2 00000002 80000000 00000001
2 FFFFFFFE 80000000 FFFFFFFF
3 FFFFFFFF FFFFFFFF FFFFFFFE
3 80000000 80000000 40000000
3 00010000 00010000 00000001
3 FFFFFFFF 00000002 00000001
4 00000014 00000006 00000003
4 FFFFFFEC 00000006 FFFFFFFD
4 00000014 FFFFFFFA FFFFFFFD
4 FFFFFFEC FFFFFFFA 00000003
4 80000000 FFFFFFFF 80000000
4 00000007 00000000 FFFFFFFF
4 FFFFFFF9 00000000 FFFFFFFF
5 FFFFFFFF 00000002 7FFFFFFF
5 80000000 00000010 08000000
5 00000064 00000000 FFFFFFFF
5 00000003 00000007 00000000
6 FFFFFFF9 00000002 FFFFFFFF
6 00000007 FFFFFFFE 00000001
6 FFFFFFEC FFFFFFFA FFFFFFFE
6 80000000 FFFFFFFF 00000000
6 FFFFFFF9 00000000 FFFFFFF9
7 FFFFFFFF 00000010 0000000F
7 00000064 00000000 00000064
7 80000000 00000003 00000002

//--- hw/muldiv_pkg.sv
`default_nettype none

package muldiv_pkg;

    // One request as presented by the caller
    typedef struct packed {
        rv_m_pkg::muldiv_op_e         op;
        logic [rv_m_pkg::xlen-1:0]    a;
        logic [rv_m_pkg::xlen-1:0]    b;
    } muldiv_req_t;

    typedef struct packed {
        logic [rv_m_pkg::xlen-1:0]    quotient;
        logic [rv_m_pkg::xlen-1:0]    remainder;
    } div_result_t;

    // One quotient bit per divide cycle, one multiplier bit per add cycle
    localparam int unsigned div_iterations = 32;
    localparam int unsigned mul_iterations = 32;

    typedef enum logic [1:0] {
        div_idle, div_init, div_divide, div_finish
    } div_state_e;

    typedef enum logic [1:0] {
        mul_idle, mul_run, mul_finish
    } mul_state_e;

    typedef enum logic [1:0] {
        seq_idle, seq_mul, seq_div
    } seq_state_e;

endpackage

`default_nettype wire

//--- hw/muldiv_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_sequencer (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           req,
    input  muldiv_pkg::muldiv_req_t        req_data,
    output logic                           busy,
    output logic                           result_valid,
    output logic [rv_m_pkg::xlen-1:0]      result,
    output logic                           mul_start,
    output logic                           a_signed,
    output logic                           b_signed,
    output logic                           div_start,
    output logic                           div_unsigned,
    output logic [rv_m_pkg::xlen-1:0]      op_a,
    output logic [rv_m_pkg::xlen-1:0]      op_b,
    input  logic                           mul_done,
    input  logic [2*rv_m_pkg::xlen-1:0]    product,
    input  logic                           div_done,
    input  muldiv_pkg::div_result_t        div_result
);

    muldiv_pkg::seq_state_e state;
    muldiv_pkg::muldiv_req_t req_q;  // Held for the whole run

    assign busy = (state != muldiv_pkg::seq_idle);

    assign op_a         = req_q.a;
    assign op_b         = req_q.b;
    assign a_signed     = (req_q.op == rv_m_pkg::op_mulh) || (req_q.op == rv_m_pkg::op_mulhsu);
    assign b_signed     = (req_q.op == rv_m_pkg::op_mulh);
    assign div_unsigned = (req_q.op == rv_m_pkg::op_divu) || (req_q.op == rv_m_pkg::op_remu);

    always_ff @(posedge clk) begin
        if (req && !busy)
            req_q <= req_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= muldiv_pkg::seq_idle;
            mul_start    <= 1'b0;
            div_start    <= 1'b0;
            result_valid <= 1'b0;
            result       <= '0;
        end else begin
            mul_start    <= 1'b0;
            div_start    <= 1'b0;
            result_valid <= 1'b0;
            case (state)
                muldiv_pkg::seq_idle: begin
                    if (req) begin
                        if (req_data.op[rv_m_pkg::op_div_bit]) begin
                            div_start <= 1'b1;
                            state     <= muldiv_pkg::seq_div;
                        end else begin
                            mul_start <= 1'b1;
                            state     <= muldiv_pkg::seq_mul;
                        end
                    end
                end
                muldiv_pkg::seq_mul: begin
                    if (mul_done) begin
                        result       <= (req_q.op == rv_m_pkg::op_mul)
                                        ? product[rv_m_pkg::xlen-1:0]
                                        : product[2*rv_m_pkg::xlen-1:rv_m_pkg::xlen];
                        result_valid <= 1'b1;
                        state        <= muldiv_pkg::seq_idle;
                    end
                end
                muldiv_pkg::seq_div: begin
                    if (div_done) begin
                        // DIV and DIVU have bit 1 of funct3 clear
                        result       <= req_q.op[1] ? div_result.remainder
                                                    : div_result.quotient;
                        result_valid <= 1'b1;
                        state        <= muldiv_pkg::seq_idle;
                    end
                end
                default: state <= muldiv_pkg::seq_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/muldiv_unit.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           req,
    input  muldiv_pkg::muldiv_req_t        req_data,
    output logic                           busy,
    output logic                           result_valid,
    output logic [rv_m_pkg::xlen-1:0]      result
);

    logic                           mul_start;
    logic                           a_signed;
    logic                           b_signed;
    logic                           div_start;
    logic                           div_unsigned;
    logic [rv_m_pkg::xlen-1:0]      op_a;
    logic [rv_m_pkg::xlen-1:0]      op_b;
    logic                           mul_done;
    logic [2*rv_m_pkg::xlen-1:0]    product;
    logic                           div_done;
    muldiv_pkg::div_result_t        div_result;

    muldiv_sequencer u_sequencer (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .req_data     (req_data),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result),
        .mul_start    (mul_start),
        .a_signed     (a_signed),
        .b_signed     (b_signed),
        .div_start    (div_start),
        .div_unsigned (div_unsigned),
        .op_a         (op_a),
        .op_b         (op_b),
        .mul_done     (mul_done),
        .product      (product),
        .div_done     (div_done),
        .div_result   (div_result)
    );

    serial_multiplier u_multiplier (
        .clk      (clk),
        .reset    (reset),
        .start    (mul_start),
        .a_signed (a_signed),
        .b_signed (b_signed),
        .a        (op_a),
        .b        (op_b),
        .done     (mul_done),
        .product  (product)
    );

    serial_divider u_divider (
        .clk         (clk),
        .reset       (reset),
        .start       (div_start),
        .is_unsigned (div_unsigned),
        .dividend    (op_a),
        .divisor     (op_b),
        .done        (div_done),
        .result      (div_result)
    );

endmodule

`default_nettype wire

//--- hw/rv_m_pkg.sv
`default_nettype none

package rv_m_pkg;

    // One machine word
    localparam int unsigned xlen = 32;

    // M-extension operations, numbered as funct3 in the R-type encoding
    typedef enum logic [2:0] {
        op_mul    = 3'd0,  // Low word of the product
        op_mulh   = 3'd1,  // High word, both operands signed
        op_mulhsu = 3'd2,  // High word, a signed and b unsigned
        op_mulhu  = 3'd3,  // High word, both operands unsigned
        op_div    = 3'd4,
        op_divu   = 3'd5,
        op_rem    = 3'd6,
        op_remu   = 3'd7
    } muldiv_op_e;

    // Bit 2 of funct3 separates divide from multiply
    localparam int unsigned op_div_bit = 2;

endpackage

`default_nettype wire

//--- hw/serial_divider.sv
`timescale 1ns/1ps
`default_nettype none

module serial_divider (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           start,
    input  logic                           is_unsigned,
    input  logic [rv_m_pkg::xlen-1:0]      dividend,
    input  logic [rv_m_pkg::xlen-1:0]      divisor,
    output logic                           done,
    output muldiv_pkg::div_result_t        result
);

    muldiv_pkg::div_state_e state;

    logic [$clog2(muldiv_pkg::div_iterations)-1:0] count;

    logic [rv_m_pkg::xlen-1:0]     abs_dividend;
    logic [rv_m_pkg::xlen-1:0]     abs_divisor;
    logic                          quo_neg;
    logic                          rem_neg;
    logic                          div_zero;

    logic [2*rv_m_pkg::xlen-1:0]   rem;
    logic [2*rv_m_pkg::xlen-1:0]   dvs;  // Divisor aligned to the bit being tried
    logic [rv_m_pkg::xlen-1:0]     quo;

    logic                          dividend_neg;
    logic                          divisor_neg;
    logic                          fits;

    assign dividend_neg = !is_unsigned && dividend[rv_m_pkg::xlen-1];
    assign divisor_neg  = !is_unsigned && divisor[rv_m_pkg::xlen-1];
    assign fits         = (dvs <= rem);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= muldiv_pkg::div_idle;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                muldiv_pkg::div_idle: begin
                    if (start)
                        state <= muldiv_pkg::div_init;
                end
                muldiv_pkg::div_init: begin
                    count <= '0;
                    state <= muldiv_pkg::div_divide;
                end
                muldiv_pkg::div_divide: begin
                    count <= count + 1'b1;
                    if (32'(count) == muldiv_pkg::div_iterations - 1)
                        state <= muldiv_pkg::div_finish;
                end
                muldiv_pkg::div_finish: begin
                    done  <= 1'b1;
                    state <= muldiv_pkg::div_idle;
                end
                default: state <= muldiv_pkg::div_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            muldiv_pkg::div_idle: begin
                if (start) begin
                    abs_dividend <= dividend_neg ? -dividend : dividend;
                    abs_divisor  <= divisor_neg ? -divisor : divisor;
                    quo_neg      <= dividend_neg ^ divisor_neg;
                    rem_neg      <= dividend_neg;
                    div_zero     <= (divisor == '0);
                end
            end
            muldiv_pkg::div_init: begin
                rem <= {{rv_m_pkg::xlen{1'b0}}, abs_dividend};
                dvs <= {1'b0, abs_divisor, {(rv_m_pkg::xlen-1){1'b0}}};
                quo <= '0;
            end
            muldiv_pkg::div_divide: begin
                if (fits)
                    rem <= rem - dvs;
                quo <= {quo[rv_m_pkg::xlen-2:0], fits};
                dvs <= dvs >> 1;
            end
            muldiv_pkg::div_finish: begin
                // A zero divisor leaves the dividend magnitude in rem, so only the quotient
                // needs overriding. The overflow case falls out of the magnitude arithmetic.
                if (div_zero)
                    result.quotient <= '1;
                else
                    result.quotient <= quo_neg ? -quo : quo;
                result.remainder <= rem_neg ? -rem[rv_m_pkg::xlen-1:0]
                                            : rem[rv_m_pkg::xlen-1:0];
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/serial_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module serial_multiplier (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  logic                            a_signed,
    input  logic                            b_signed,
    input  logic [rv_m_pkg::xlen-1:0]       a,
    input  logic [rv_m_pkg::xlen-1:0]       b,
    output logic                            done,
    output logic [2*rv_m_pkg::xlen-1:0]     product
);

    muldiv_pkg::mul_state_e state;

    logic [$clog2(muldiv_pkg::mul_iterations)-1:0] count;

    logic [2*rv_m_pkg::xlen-1:0]   mcand;   // Multiplicand, shifted left every cycle
    logic [rv_m_pkg::xlen-1:0]     mplier;  // Multiplier, shifted right every cycle
    logic [2*rv_m_pkg::xlen-1:0]   acc;
    logic                          neg;

    logic                          a_neg;
    logic                          b_neg;

    assign a_neg = a_signed && a[rv_m_pkg::xlen-1];
    assign b_neg = b_signed && b[rv_m_pkg::xlen-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= muldiv_pkg::mul_idle;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                muldiv_pkg::mul_idle: begin
                    count <= '0;
                    if (start)
                        state <= muldiv_pkg::mul_run;
                end
                muldiv_pkg::mul_run: begin
                    count <= count + 1'b1;
                    if (32'(count) == muldiv_pkg::mul_iterations - 1)
                        state <= muldiv_pkg::mul_finish;
                end
                muldiv_pkg::mul_finish: begin
                    done  <= 1'b1;
                    state <= muldiv_pkg::mul_idle;
                end
                default: state <= muldiv_pkg::mul_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            muldiv_pkg::mul_idle: begin
                if (start) begin
                    mcand  <= {{rv_m_pkg::xlen{1'b0}}, (a_neg ? -a : a)};
                    mplier <= b_neg ? -b : b;
                    neg    <= a_neg ^ b_neg;
                    acc    <= '0;
                end
            end
            muldiv_pkg::mul_run: begin
                if (mplier[0])
                    acc <= acc + mcand;
                mcand  <= mcand << 1;
                mplier <= mplier >> 1;
            end
            muldiv_pkg::mul_finish: product <= neg ? -acc : acc;  // Sign fix on the full 64 bits
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- muldiv_unit.f
hw/rv_m_pkg.sv
hw/muldiv_pkg.sv
hw/serial_divider.sv
hw/serial_multiplier.sv
hw/muldiv_sequencer.sv
hw/muldiv_unit.sv
bench/muldiv_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the muldiv_unit testbench with Verilator, runs it and checks for the pass line

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module muldiv_unit_tb -f muldiv_unit.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vmuldiv_unit_tb)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
